// ==== ibuf.f ====
+incdir+tests
common/ibuf_pkg.sv
ibuf/ibuf_ctrl.sv
ibuf/ibuf_lane_select.sv
ibuf/ibuf_storage.sv
ibuf/ibuf_top.sv
tests/ibuf_tb.sv

// ==== Makefile ====
# Verilator build and run of the instruction buffer testbench

VERILATOR ?= verilator
TOP       ?= ibuf_tb
FILELIST  ?= ibuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= RESULT: PASS

SOURCES := $(wildcard common/*.sv ibuf/*.sv tests/*.sv tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/ibuf_tb_table.svh ====
// Stimulus rows, applied in order from row 0
// Columns: fetch slots, decode_ready mask, flush, repeat count,
// then the status after the last edge of the row: fetch_ready, full, occupancy

localparam int NUM_ROWS = 17;

string row_name [NUM_ROWS] = '{
    "after_reset", "write_five", "read_three", "read_two",
    "write_four", "mask_0_2", "mask_2_only", "mask_1_2_short",
    "fill_four", "fill_three", "fill_to_full", "offer_blocked",
    "stream_wrap", "stream_mixed", "flush", "write_after_flush",
    "read_after_flush"
};

row_t rows [NUM_ROWS] = '{
    // slots  ready   flush  reps  ready  full  occ
    '{0,      3'b111, 1'b0,  1,    1'b1,  1'b0, 0 },
    '{5,      3'b111, 1'b0,  1,    1'b1,  1'b0, 5 },   // Not readable in the write cycle
    '{0,      3'b111, 1'b0,  1,    1'b1,  1'b0, 2 },
    '{0,      3'b111, 1'b0,  1,    1'b1,  1'b0, 0 },   // Lane 2 idle
    '{4,      3'b000, 1'b0,  1,    1'b1,  1'b0, 4 },
    '{0,      3'b101, 1'b0,  1,    1'b1,  1'b0, 2 },
    '{0,      3'b100, 1'b0,  1,    1'b1,  1'b0, 1 },
    '{0,      3'b110, 1'b0,  1,    1'b1,  1'b0, 0 },   // Only one entry for two lanes
    '{4,      3'b000, 1'b0,  2,    1'b1,  1'b0, 8 },
    '{3,      3'b000, 1'b0,  1,    1'b1,  1'b0, 11},
    '{2,      3'b000, 1'b0,  1,    1'b0,  1'b1, 13},
    '{5,      3'b000, 1'b0,  3,    1'b0,  1'b1, 13},   // Offered slots are dropped
    '{3,      3'b111, 1'b0,  8,    1'b1,  1'b0, 10},   // Pointers wrap several times
    '{5,      3'b011, 1'b0,  4,    1'b0,  1'b0, 12},
    '{5,      3'b111, 1'b1,  1,    1'b0,  1'b0, 0 },
    '{5,      3'b000, 1'b0,  1,    1'b1,  1'b0, 5 },
    '{0,      3'b111, 1'b0,  2,    1'b1,  1'b0, 0 }
};

// ==== tests/ibuf_tb.sv ====
module ibuf_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ibuf_pkg::*;

    typedef struct packed {
        int                  slots;      // Valid fetch slots from slot 0
        logic [DECODE_W-1:0] ready;
        logic                flush;
        int                  reps;
        logic                exp_ready;  // Status after the last edge of the row
        logic                exp_full;
        int                  exp_occ;
    } row_t;

    `include "ibuf_tb_table.svh"

    logic                clk;
    logic                reset;
    logic [FETCH_W-1:0]  fetch_valid_i;
    fetch_bundle_t       fetch_i;
    logic                fetch_ready_o;
    logic [DECODE_W-1:0] decode_ready_i;
    logic [DECODE_W-1:0] decode_valid_o;
    decode_bundle_t      decode_o;
    logic                flush_i;
    logic                buffer_empty_o;
    logic                buffer_full_o;
    logic [CNT_W-1:0]    occupancy_o;

    ibuf_entry_t     model_q [$];   // Reference queue, oldest first
    ibuf_entry_t     nop_entry;
    fetch_bundle_t   held_bundle;   // Held until fetch takes it
    logic            need_bundle;
    logic [XLEN-1:0] next_pc;
    logic            exp_accept;
    int              exp_grants;
    string           cur_name;
    int              err_count;
    int              rows_passed;
    int              rows_failed;

    ibuf_top dut (
        .clk            (clk),
        .reset          (reset),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_i        (fetch_i),
        .fetch_ready_o  (fetch_ready_o),
        .decode_ready_i (decode_ready_i),
        .decode_valid_o (decode_valid_o),
        .decode_o       (decode_o),
        .flush_i        (flush_i),
        .buffer_empty_o (buffer_empty_o),
        .buffer_full_o  (buffer_full_o),
        .occupancy_o    (occupancy_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [255:0] expected,
                                   input logic [255:0] actual);
        $display("mismatch %s %s: expected %0h actual %0h", cur_name, what, expected, actual);
        err_count++;
    endtask

    // Fresh payloads, PCs keep counting up by 4
    task automatic new_bundle();
        for (int k = 0; k < FETCH_W; k++) begin
            held_bundle[k].insn            = $urandom;
            held_bundle[k].pc              = next_pc + XLEN'(4 * k);
            held_bundle[k].imm             = $urandom;
            held_bundle[k].pred.taken      = 1'($urandom);
            held_bundle[k].pred.pc_at_pred = next_pc + XLEN'(4 * k);
            held_bundle[k].pred.ghist      = GHIST_W'($urandom);
            held_bundle[k].pred.ras_tos    = RAS_W'($urandom);
        end
        need_bundle = 1'b0;
    endtask

    task automatic apply_row(input row_t row);
        if (need_bundle) begin
            new_bundle();
        end
        fetch_valid_i  = FETCH_W'((1 << row.slots) - 1);
        fetch_i        = held_bundle;
        decode_ready_i = row.ready;
        flush_i        = row.flush;
    endtask

    // Grants go to the first ready lanes, as many as entries are stored
    task automatic check_cycle(input row_t row);
        int                  avail;
        int                  j;
        logic [DECODE_W-1:0] exp_valid;
        logic                exp_full;
        logic                exp_empty;
        ibuf_entry_t         exp_lane;
        avail      = row.flush ? 0 : model_q.size();
        exp_grants = $countones(row.ready);
        if (exp_grants > avail) begin
            exp_grants = avail;
        end
        exp_accept = !row.flush && (model_q.size() <= BUF_DEPTH - FETCH_W);
        exp_full   = (model_q.size() >= BUF_DEPTH - DECODE_W);
        exp_empty  = (model_q.size() == 0);
        j = 0;
        for (int k = 0; k < DECODE_W; k++) begin
            exp_valid[k] = 1'b0;
            exp_lane     = nop_entry;
            if (row.ready[k] && j < exp_grants) begin
                exp_valid[k] = 1'b1;
                exp_lane     = model_q[j];
                j++;
            end
            if (decode_o[k] !== exp_lane) begin
                report_mismatch($sformatf("lane %0d entry", k), 256'(exp_lane),
                                256'(decode_o[k]));
            end
        end
        if (decode_valid_o !== exp_valid) begin
            report_mismatch("decode_valid", 256'(exp_valid), 256'(decode_valid_o));
        end
        if (fetch_ready_o !== exp_accept) begin
            report_mismatch("fetch_ready", 256'(exp_accept), 256'(fetch_ready_o));
        end
        if (buffer_full_o !== exp_full) begin
            report_mismatch("buffer_full", 256'(exp_full), 256'(buffer_full_o));
        end
        if (buffer_empty_o !== exp_empty) begin
            report_mismatch("buffer_empty", 256'(exp_empty), 256'(buffer_empty_o));
        end
        if (occupancy_o !== CNT_W'(model_q.size())) begin
            report_mismatch("occupancy", 256'(model_q.size()), 256'(occupancy_o));
        end
    endtask

    task automatic advance_model(input row_t row);
        if (row.flush) begin
            model_q.delete();
        end else begin
            for (int k = 0; k < exp_grants; k++) begin
                void'(model_q.pop_front());
            end
            if (exp_accept && row.slots > 0) begin
                for (int k = 0; k < row.slots; k++) begin
                    model_q.push_back(held_bundle[k]);
                end
                next_pc     = next_pc + XLEN'(4 * row.slots);
                need_bundle = 1'b1;
            end
        end
    endtask

    task automatic check_row_status(input row_t row);
        if (fetch_ready_o !== row.exp_ready) begin
            report_mismatch("final fetch_ready", 256'(row.exp_ready), 256'(fetch_ready_o));
        end
        if (buffer_full_o !== row.exp_full) begin
            report_mismatch("final buffer_full", 256'(row.exp_full), 256'(buffer_full_o));
        end
        if (occupancy_o !== CNT_W'(row.exp_occ)) begin
            report_mismatch("final occupancy", 256'(row.exp_occ), 256'(occupancy_o));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int row_errs;
        void'($urandom(32'h4f47));
        reset          = 1'b0;
        flush_i        = 1'b0;
        fetch_valid_i  = '0;
        fetch_i        = '0;
        decode_ready_i = '0;
        nop_entry      = '0;
        nop_entry.insn = 32'h0000_0013;   // addi x0, x0, 0
        next_pc        = 32'h0000_1000;
        need_bundle    = 1'b1;
        err_count      = 0;
        rows_passed    = 0;
        rows_failed    = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_name = row_name[r];
            row_errs = err_count;
            for (int i = 0; i < rows[r].reps; i++) begin
                apply_row(rows[r]);
                @(negedge clk);
                check_cycle(rows[r]);
                @(posedge clk);
                advance_model(rows[r]);
                #1;
            end
            check_row_status(rows[r]);
            if (err_count == row_errs) begin
                rows_passed++;
                $display("row %s passed after %0d cycles", cur_name, rows[r].reps);
            end else begin
                rows_failed++;
                $display("row %s failed with %0d mismatches", cur_name, err_count - row_errs);
            end
        end
        $display("rows passed %0d, rows failed %0d, mismatches %0d",
                 rows_passed, rows_failed, err_count);
        if (rows_failed == 0 && err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Reset and margin fit in the extra 20 cycles
    initial begin : watchdog
        int total;
        total = 20;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += rows[r].reps;
        end
        #(total * 8);
        $display("timeout: the run did not finish within %0d cycles", total);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== ibuf/ibuf_top.sv ====
module ibuf_top (
    input  logic                          clk,
    input  logic                          reset,
    // Fetch side
    input  logic [ibuf_pkg::FETCH_W-1:0]  fetch_valid_i,
    input  ibuf_pkg::fetch_bundle_t       fetch_i,
    output logic                          fetch_ready_o,
    // Decode side
    input  logic [ibuf_pkg::DECODE_W-1:0] decode_ready_i,
    output logic [ibuf_pkg::DECODE_W-1:0] decode_valid_o,
    output ibuf_pkg::decode_bundle_t      decode_o,
    input  logic                          flush_i,
    // Status
    output logic                          buffer_empty_o,
    output logic                          buffer_full_o,
    output logic [ibuf_pkg::CNT_W-1:0]    occupancy_o
);

    import ibuf_pkg::*;

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] avail_cnt;   // Zero during flush
    lane_offset_t     lane_offset;

    ibuf_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .lane_valid_i   (decode_valid_o),
        .head_ptr_o     (head_ptr),
        .tail_ptr_o     (tail_ptr),
        .avail_cnt_o    (avail_cnt),
        .fetch_ready_o  (fetch_ready_o),
        .buffer_empty_o (buffer_empty_o),
        .buffer_full_o  (buffer_full_o),
        .occupancy_o    (occupancy_o)
    );

    ibuf_lane_select u_lane_select (
        .avail_cnt_i    (avail_cnt),
        .decode_ready_i (decode_ready_i),
        .lane_valid_o   (decode_valid_o),
        .lane_offset_o  (lane_offset)
    );

    ibuf_storage u_storage (
        .clk           (clk),
        .fetch_we_i    (fetch_ready_o),     // Write only when the bundle is accepted
        .fetch_valid_i (fetch_valid_i),
        .fetch_i       (fetch_i),
        .tail_ptr_i    (tail_ptr),
        .head_ptr_i    (head_ptr),
        .lane_valid_i  (decode_valid_o),
        .lane_offset_i (lane_offset),
        .decode_o      (decode_o)
    );

endmodule

// ==== ibuf/ibuf_storage.sv ====
module ibuf_storage (
    input  logic                          clk,
    input  logic                          fetch_we_i,
    input  logic [ibuf_pkg::FETCH_W-1:0]  fetch_valid_i,
    input  ibuf_pkg::fetch_bundle_t       fetch_i,
    input  logic [ibuf_pkg::PTR_W-1:0]    tail_ptr_i,
    input  logic [ibuf_pkg::PTR_W-1:0]    head_ptr_i,
    input  logic [ibuf_pkg::DECODE_W-1:0] lane_valid_i,
    input  ibuf_pkg::lane_offset_t        lane_offset_i,
    output ibuf_pkg::decode_bundle_t      decode_o
);

    import ibuf_pkg::*;

    ibuf_entry_t mem [BUF_DEPTH];

    logic [FETCH_W-1:0][PTR_W-1:0]  wr_idx;
    logic [DECODE_W-1:0][PTR_W-1:0] rd_idx;

    //////////////////////////////////////////////////////////////////////
    // Five-slot write port
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < FETCH_W; k++) begin
            wr_idx[k] = tail_ptr_i + PTR_W'(k);     // Wraps past the last entry
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_we_i) begin
            for (int k = 0; k < FETCH_W; k++) begin
                if (fetch_valid_i[k]) begin
                    mem[wr_idx[k]] <= fetch_i[k];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Three-lane read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < DECODE_W; k++) begin
            rd_idx[k] = head_ptr_i + lane_offset_i[k];
            // Idle lane shows a NOP with zero fields
            decode_o[k]      = '0;
            decode_o[k].insn = INSN_NOP;
            if (lane_valid_i[k]) begin
                decode_o[k] = mem[rd_idx[k]];
            end
        end
    end

endmodule

// ==== ibuf/ibuf_lane_select.sv ====
module ibuf_lane_select (
    input  logic [ibuf_pkg::CNT_W-1:0]    avail_cnt_i,
    input  logic [ibuf_pkg::DECODE_W-1:0] decode_ready_i,
    output logic [ibuf_pkg::DECODE_W-1:0] lane_valid_o,
    output ibuf_pkg::lane_offset_t        lane_offset_o
);

    import ibuf_pkg::*;

    // Running totals over the lanes below the current one
    logic [CNT_W-1:0] ready_below;
    logic [PTR_W-1:0] grant_below;

    //////////////////////////////////////////////////////////////////////
    // Compacted grant
    //////////////////////////////////////////////////////////////////////

    // A ready lane needs an entry for itself and for each ready lane
    // below it, so the oldest entries go to the lowest ready lanes
    always_comb begin
        ready_below = '0;
        grant_below = '0;
        for (int k = 0; k < DECODE_W; k++) begin
            lane_valid_o[k]  = decode_ready_i[k] && (avail_cnt_i > ready_below);
            lane_offset_o[k] = grant_below;     // Skips idle lanes
            ready_below = ready_below + CNT_W'(decode_ready_i[k]);
            grant_below = grant_below + PTR_W'(lane_valid_o[k]);
        end
    end

endmodule

// ==== ibuf/ibuf_ctrl.sv ====
module ibuf_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_i,
    input  logic [ibuf_pkg::FETCH_W-1:0]  fetch_valid_i,
    input  logic [ibuf_pkg::DECODE_W-1:0] lane_valid_i,
    output logic [ibuf_pkg::PTR_W-1:0]    head_ptr_o,
    output logic [ibuf_pkg::PTR_W-1:0]    tail_ptr_o,
    output logic [ibuf_pkg::CNT_W-1:0]    avail_cnt_o,
    output logic                          fetch_ready_o,
    output logic                          buffer_empty_o,
    output logic                          buffer_full_o,
    output logic [ibuf_pkg::CNT_W-1:0]    occupancy_o
);

    import ibuf_pkg::*;

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;

    logic [CNT_W-1:0] wr_cnt;   // Slots stored this cycle
    logic [CNT_W-1:0] rd_cnt;   // Lanes granted this cycle

    //////////////////////////////////////////////////////////////////////
    // Flow control and status
    //////////////////////////////////////////////////////////////////////

    // Conservative, a whole bundle must always fit
    assign fetch_ready_o  = !flush_i && (count <= CNT_W'(BUF_DEPTH - FETCH_W));
    assign buffer_full_o  = (count >= CNT_W'(BUF_DEPTH - DECODE_W));
    assign buffer_empty_o = (count == '0);
    assign occupancy_o    = count;

    // Read side sees nothing while flushing
    assign avail_cnt_o = flush_i ? '0 : count;

    assign head_ptr_o = head_ptr;
    assign tail_ptr_o = tail_ptr;

    // Population counts of accepted slots and granted lanes
    always_comb begin
        wr_cnt = '0;
        rd_cnt = '0;
        for (int k = 0; k < FETCH_W; k++) begin
            wr_cnt = wr_cnt + CNT_W'(fetch_valid_i[k]);
        end
        if (!fetch_ready_o) begin
            wr_cnt = '0;                // Offered bundle is not taken
        end
        for (int k = 0; k < DECODE_W; k++) begin
            rd_cnt = rd_cnt + CNT_W'(lane_valid_i[k]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            tail_ptr <= tail_ptr + PTR_W'(wr_cnt);
            head_ptr <= head_ptr + PTR_W'(rd_cnt);
            count    <= count + wr_cnt - rd_cnt;
        end
    end

endmodule

// ==== common/ibuf_pkg.sv ====
package ibuf_pkg;

    //////////////////////////////////////////////////////////////////////
    // Buffer geometry
    //////////////////////////////////////////////////////////////////////

    localparam int BUF_DEPTH = 16;                // Entries, power of two
    localparam int PTR_W     = $clog2(BUF_DEPTH);
    localparam int CNT_W     = PTR_W + 1;         // Count reaches BUF_DEPTH
    localparam int FETCH_W   = 5;                 // Fetch slots per cycle
    localparam int DECODE_W  = 3;                 // Decode lanes

    localparam int XLEN      = 32;
    localparam int GHIST_W   = 8;                 // Predictor index width plus three
    localparam int RAS_W     = 3;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] INSN_NOP = 32'h0000_0013;

    //////////////////////////////////////////////////////////////////////
    // Payload types
    //////////////////////////////////////////////////////////////////////

    // Branch prediction record, one per slot
    typedef struct packed {
        logic               taken;
        logic [XLEN-1:0]    pc_at_pred;
        logic [GHIST_W-1:0] ghist;
        logic [RAS_W-1:0]   ras_tos;      // RAS checkpoint travels with the slot
    } pred_t;

    typedef struct packed {
        logic [XLEN-1:0] insn;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        pred_t           pred;
    } ibuf_entry_t;

    typedef ibuf_entry_t [FETCH_W-1:0]  fetch_bundle_t;
    typedef ibuf_entry_t [DECODE_W-1:0] decode_bundle_t;

    // Read offset of each lane, counted from the head
    typedef logic [DECODE_W-1:0][PTR_W-1:0] lane_offset_t;

endpackage
